//--- br_pkg.sv
`default_nettype none

package br_pkg;

    // datapath widths
    localparam int XLEN      = 32;
    localparam int TAG_W     = 6;   // physical register tag
    localparam int NUM_PREGS = 64;

    // branch reservation station sizing
    localparam int RS_DEPTH  = 8;
    localparam int RS_PTR_W  = 3;   // log2 of RS_DEPTH

    // branch and jump opcodes as decoded by dispatch
    typedef enum logic [2:0] {
        OP_BEQ  = 3'd0,
        OP_BNE  = 3'd1,
        OP_BLT  = 3'd2,
        OP_BGE  = 3'd3,
        OP_BLTU = 3'd4,
        OP_BGEU = 3'd5,
        OP_JAL  = 3'd6,  // unconditional, pc relative
        OP_JALR = 3'd7   // unconditional, register relative
    } br_op_e;

endpackage

`default_nettype wire

//--- phys_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module phys_reg_file import br_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             alu_wb_valid,
    input  logic [TAG_W-1:0] alu_wb_tag,
    input  logic [XLEN-1:0]  alu_wb_data,
    input  logic             ld_wb_valid,
    input  logic [TAG_W-1:0] ld_wb_tag,
    input  logic [XLEN-1:0]  ld_wb_data,
    input  logic [TAG_W-1:0] rd_tag_a,
    input  logic [TAG_W-1:0] rd_tag_b,
    output logic [XLEN-1:0]  rd_data_a,
    output logic [XLEN-1:0]  rd_data_b
);

    logic [XLEN-1:0] regs [NUM_PREGS];

    // load port is written last so it wins on a tag clash
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (alu_wb_valid) regs[alu_wb_tag] <= alu_wb_data;
            if (ld_wb_valid)  regs[ld_wb_tag]  <= ld_wb_data;
        end
    end

    // same priority on the bypass path as on the write
    function automatic logic [XLEN-1:0] read_port(input logic [TAG_W-1:0] tag);
        if (ld_wb_valid && ld_wb_tag == tag) begin
            read_port = ld_wb_data;
        end else if (alu_wb_valid && alu_wb_tag == tag) begin
            read_port = alu_wb_data;
        end else begin
            read_port = regs[tag];
        end
    endfunction

    always_comb begin
        rd_data_a = read_port(rd_tag_a);
        rd_data_b = read_port(rd_tag_b);
    end

endmodule

`default_nettype wire

//--- branch_rs.sv
`timescale 1ns/1ps
`default_nettype none

module branch_rs import br_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    // dispatch
    input  logic             disp_valid,
    output logic             disp_ready,
    input  br_op_e           disp_op,
    input  logic [XLEN-1:0]  disp_pc,
    input  logic [XLEN-1:0]  disp_imm,
    input  logic [TAG_W-1:0] disp_rs1,
    input  logic [TAG_W-1:0] disp_rs2,
    input  logic             disp_rs1_rdy,
    input  logic             disp_rs2_rdy,
    input  logic [TAG_W-1:0] disp_rd,
    input  logic             disp_pred_taken,
    input  logic [XLEN-1:0]  disp_pred_target,
    // wakeup
    input  logic             alu_wb_valid,
    input  logic [TAG_W-1:0] alu_wb_tag,
    input  logic             ld_wb_valid,
    input  logic [TAG_W-1:0] ld_wb_tag,
    // issue
    input  logic             iss_ready,
    output logic             iss_valid,
    output br_op_e           iss_op,
    output logic [XLEN-1:0]  iss_pc,
    output logic [XLEN-1:0]  iss_imm,
    output logic [TAG_W-1:0] iss_rs1,
    output logic [TAG_W-1:0] iss_rs2,
    output logic [TAG_W-1:0] iss_rd,
    output logic             iss_pred_taken,
    output logic [XLEN-1:0]  iss_pred_target
);

    br_op_e              ent_op          [RS_DEPTH];
    logic [XLEN-1:0]     ent_pc          [RS_DEPTH];
    logic [XLEN-1:0]     ent_imm         [RS_DEPTH];
    logic [TAG_W-1:0]    ent_rs1         [RS_DEPTH];
    logic [TAG_W-1:0]    ent_rs2         [RS_DEPTH];
    logic [TAG_W-1:0]    ent_rd          [RS_DEPTH];
    logic [XLEN-1:0]     ent_pred_target [RS_DEPTH];
    logic [RS_DEPTH-1:0] ent_pred_taken;
    logic [RS_DEPTH-1:0] ent_rs1_rdy;
    logic [RS_DEPTH-1:0] ent_rs2_rdy;

    logic [RS_PTR_W-1:0] head;
    logic [RS_PTR_W-1:0] tail;
    logic [RS_PTR_W:0]   count;   // one extra bit to tell full from empty
    logic                full;
    logic                disp_fire;
    logic                head_rdy;
    logic                pop;

    // tag seen on either writeback port this cycle
    function automatic logic woken(input logic [TAG_W-1:0] tag);
        woken = (alu_wb_valid && alu_wb_tag == tag) || (ld_wb_valid && ld_wb_tag == tag);
    endfunction

    assign full       = (count == (RS_PTR_W+1)'(RS_DEPTH));
    assign disp_ready = !full && !flush;
    assign disp_fire  = disp_valid && disp_ready;

    always_comb begin
        head_rdy = (count != '0)
                   && (ent_rs1_rdy[head] || woken(ent_rs1[head]))
                   && (ent_rs2_rdy[head] || woken(ent_rs2[head]));
    end

    assign pop = head_rdy && (!iss_valid || iss_ready);  // strictly in order from head

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            iss_valid <= 1'b0;
        end else begin
            if (disp_fire) tail <= tail + 1'b1;
            if (pop)       head <= head + 1'b1;

            if (pop) begin
                iss_valid <= 1'b1;
            end else if (iss_ready) begin
                iss_valid <= 1'b0;
            end

            case ({disp_fire, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry payload and ready bits, liveness comes from count
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (woken(ent_rs1[i])) ent_rs1_rdy[i] <= 1'b1;
            if (woken(ent_rs2[i])) ent_rs2_rdy[i] <= 1'b1;
        end

        if (disp_fire) begin
            ent_op[tail]          <= disp_op;
            ent_pc[tail]          <= disp_pc;
            ent_imm[tail]         <= disp_imm;
            ent_rs1[tail]         <= disp_rs1;
            ent_rs2[tail]         <= disp_rs2;
            ent_rd[tail]          <= disp_rd;
            ent_pred_taken[tail]  <= disp_pred_taken;
            ent_pred_target[tail] <= disp_pred_target;
            ent_rs1_rdy[tail]     <= disp_rs1_rdy || woken(disp_rs1);  // catch same cycle wb
            ent_rs2_rdy[tail]     <= disp_rs2_rdy || woken(disp_rs2);
        end

        if (pop) begin
            iss_op          <= ent_op[head];
            iss_pc          <= ent_pc[head];
            iss_imm         <= ent_imm[head];
            iss_rs1         <= ent_rs1[head];
            iss_rs2         <= ent_rs2[head];
            iss_rd          <= ent_rd[head];
            iss_pred_taken  <= ent_pred_taken[head];
            iss_pred_target <= ent_pred_target[head];
        end
    end

endmodule

`default_nettype wire

//--- branch_compare.sv
`timescale 1ns/1ps
`default_nettype none

module branch_compare import br_pkg::*; (
    input  br_op_e          op,
    input  logic [XLEN-1:0] rs1_val,
    input  logic [XLEN-1:0] rs2_val,
    output logic            taken
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (rs1_val == rs2_val);
    assign lt_s = ($signed(rs1_val) < $signed(rs2_val));
    assign lt_u = (rs1_val < rs2_val);

    always_comb begin
        case (op)
            OP_BEQ:  taken = eq;
            OP_BNE:  taken = !eq;
            OP_BLT:  taken = lt_s;
            OP_BGE:  taken = !lt_s;
            OP_BLTU: taken = lt_u;
            OP_BGEU: taken = !lt_u;
            OP_JAL,
            OP_JALR: taken = 1'b1;  // jumps always redirect
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- branch_target.sv
`timescale 1ns/1ps
`default_nettype none

module branch_target import br_pkg::*; (
    input  br_op_e          op,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] rs1_val,
    output logic [XLEN-1:0] target,
    output logic [XLEN-1:0] link,
    output logic            misaligned
);

    logic            is_jalr;
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] sum;

    assign is_jalr = (op == OP_JALR);
    assign base    = is_jalr ? rs1_val : pc;  // register relative only for jalr
    assign sum     = base + imm;

    // jalr drops bit 0 of the computed address
    assign target = is_jalr ? {sum[XLEN-1:1], 1'b0} : sum;

    assign link = pc + 32'd4;

    // 32 bit instructions, no compressed support
    assign misaligned = target[1];

endmodule

`default_nettype wire

//--- branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module branch_resolve import br_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             iss_valid,
    input  logic [XLEN-1:0]  iss_pc,
    input  logic [TAG_W-1:0] iss_rd,
    input  logic             iss_pred_taken,
    input  logic [XLEN-1:0]  iss_pred_target,
    input  logic             taken,
    input  logic [XLEN-1:0]  target,
    input  logic [XLEN-1:0]  link,
    input  logic             misaligned,
    output logic             iss_ready,
    output logic             flush,
    output logic             res_valid,
    input  logic             res_ready,
    output logic             res_taken,
    output logic [XLEN-1:0]  res_next_pc,
    output logic [XLEN-1:0]  res_link,
    output logic [TAG_W-1:0] res_rd,
    output logic             res_mispredict,
    output logic             res_misaligned
);

    logic            load;
    logic            mispredict;
    logic [XLEN-1:0] next_pc;

    assign iss_ready = !res_valid || res_ready;
    assign load      = iss_valid && iss_ready && !flush;  // wrong path item is dropped

    assign next_pc    = taken ? target : iss_pc + 32'd4;
    assign mispredict = (taken != iss_pred_taken)
                        || (taken && target != iss_pred_target);

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
            flush     <= 1'b0;
        end else begin
            flush <= load && mispredict;  // one cycle, right after the load
            if (load) begin
                res_valid <= 1'b1;
            end else if (res_ready) begin
                res_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            res_taken      <= taken;
            res_next_pc    <= next_pc;
            res_link       <= link;
            res_rd         <= iss_rd;
            res_mispredict <= mispredict;
            res_misaligned <= taken && misaligned;  // only a redirect can fault
        end
    end

endmodule

`default_nettype wire

//--- branch_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module branch_exec_top import br_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    // dispatch
    input  logic             disp_valid,
    output logic             disp_ready,
    input  br_op_e           disp_op,
    input  logic [XLEN-1:0]  disp_pc,
    input  logic [XLEN-1:0]  disp_imm,
    input  logic [TAG_W-1:0] disp_rs1,
    input  logic [TAG_W-1:0] disp_rs2,
    input  logic             disp_rs1_rdy,
    input  logic             disp_rs2_rdy,
    input  logic [TAG_W-1:0] disp_rd,
    input  logic             disp_pred_taken,
    input  logic [XLEN-1:0]  disp_pred_target,
    // writeback
    input  logic             alu_wb_valid,
    input  logic [TAG_W-1:0] alu_wb_tag,
    input  logic [XLEN-1:0]  alu_wb_data,
    input  logic             ld_wb_valid,
    input  logic [TAG_W-1:0] ld_wb_tag,
    input  logic [XLEN-1:0]  ld_wb_data,
    // result
    output logic             res_valid,
    input  logic             res_ready,
    output logic             res_taken,
    output logic [XLEN-1:0]  res_next_pc,
    output logic [XLEN-1:0]  res_link,
    output logic [TAG_W-1:0] res_rd,
    output logic             res_mispredict,
    output logic             res_misaligned
);

    logic             flush;
    logic             iss_valid;
    logic             iss_ready;
    br_op_e           iss_op;
    logic [XLEN-1:0]  iss_pc;
    logic [XLEN-1:0]  iss_imm;
    logic [TAG_W-1:0] iss_rs1;
    logic [TAG_W-1:0] iss_rs2;
    logic [TAG_W-1:0] iss_rd;
    logic             iss_pred_taken;
    logic [XLEN-1:0]  iss_pred_target;
    logic [XLEN-1:0]  rs1_val;
    logic [XLEN-1:0]  rs2_val;
    logic             taken;
    logic [XLEN-1:0]  target;
    logic [XLEN-1:0]  link;
    logic             misaligned;

    phys_reg_file i_phys_reg_file (
        .clk, .reset,
        .alu_wb_valid, .alu_wb_tag, .alu_wb_data,
        .ld_wb_valid, .ld_wb_tag, .ld_wb_data,
        .rd_tag_a  (iss_rs1),
        .rd_tag_b  (iss_rs2),
        .rd_data_a (rs1_val),
        .rd_data_b (rs2_val)
    );

    branch_rs i_branch_rs (
        .clk, .reset, .flush,
        .disp_valid, .disp_ready, .disp_op, .disp_pc, .disp_imm,
        .disp_rs1, .disp_rs2, .disp_rs1_rdy, .disp_rs2_rdy, .disp_rd,
        .disp_pred_taken, .disp_pred_target,
        .alu_wb_valid, .alu_wb_tag, .ld_wb_valid, .ld_wb_tag,
        .iss_ready, .iss_valid, .iss_op, .iss_pc, .iss_imm,
        .iss_rs1, .iss_rs2, .iss_rd, .iss_pred_taken, .iss_pred_target
    );

    branch_compare i_branch_compare (
        .op (iss_op), .rs1_val, .rs2_val, .taken
    );

    branch_target i_branch_target (
        .op (iss_op), .pc (iss_pc), .imm (iss_imm), .rs1_val,
        .target, .link, .misaligned
    );

    branch_resolve i_branch_resolve (
        .clk, .reset,
        .iss_valid, .iss_pc, .iss_rd, .iss_pred_taken, .iss_pred_target,
        .taken, .target, .link, .misaligned,
        .iss_ready, .flush,
        .res_valid, .res_ready, .res_taken, .res_next_pc, .res_link,
        .res_rd, .res_mispredict, .res_misaligned
    );

endmodule

`default_nettype wire

//--- tb_branch_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_branch_exec import br_pkg::*; ();

    typedef struct packed {
        br_op_e      op;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [5:0]  t1;
        logic [5:0]  t2;
        logic [5:0]  rd;
        logic        pt;
        logic [31:0] ptgt;
        logic        late;     // operands broadcast after dispatch
        logic        shadow;   // second branch dispatched right behind
    } row_t;

    typedef struct packed {
        logic [7:0]  idx;
        br_op_e      op;
        logic        taken;
        logic [31:0] next_pc;
        logic [31:0] link;
        logic [5:0]  rd;
        logic        mispredict;
        logic        misaligned;
    } exp_t;

    logic             clk = 1'b0;
    logic             reset = 1'b1;
    logic             disp_valid = 1'b0;
    logic             disp_ready;
    br_op_e           disp_op = OP_BEQ;
    logic [XLEN-1:0]  disp_pc = '0;
    logic [XLEN-1:0]  disp_imm = '0;
    logic [TAG_W-1:0] disp_rs1 = '0;
    logic [TAG_W-1:0] disp_rs2 = '0;
    logic             disp_rs1_rdy = 1'b0;
    logic             disp_rs2_rdy = 1'b0;
    logic [TAG_W-1:0] disp_rd = '0;
    logic             disp_pred_taken = 1'b0;
    logic [XLEN-1:0]  disp_pred_target = '0;
    logic             alu_wb_valid = 1'b0;
    logic [TAG_W-1:0] alu_wb_tag = '0;
    logic [XLEN-1:0]  alu_wb_data = '0;
    logic             ld_wb_valid = 1'b0;
    logic [TAG_W-1:0] ld_wb_tag = '0;
    logic [XLEN-1:0]  ld_wb_data = '0;
    logic             res_valid;
    logic             res_ready = 1'b0;
    logic             res_taken;
    logic [XLEN-1:0]  res_next_pc;
    logic [XLEN-1:0]  res_link;
    logic [TAG_W-1:0] res_rd;
    logic             res_mispredict;
    logic             res_misaligned;

    row_t        rows[$];
    exp_t        exp_q[$];
    int          errors = 0;
    int          tests = 0;
    int          cycles = 0;
    int          limit = 100000;
    logic        row_ok;
    logic        flush_seen;
    int unsigned rng_init;

    branch_exec_top i_branch_exec_top (.*);

    always #2 clk = ~clk;

    always @(negedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("run stopped at the cycle limit of %0d before all rows completed", limit);
            $display("tests failed");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
            row_ok = 1'b0;
        end
    endtask

    task automatic add_row(input br_op_e op, input logic [31:0] pc, imm, v1, v2,
                           input logic [5:0] t1, t2, rd, input logic pt,
                           input logic [31:0] ptgt, input logic late, shadow);
        rows.push_back({op, pc, imm, v1, v2, t1, t2, rd, pt, ptgt, late, shadow});
    endtask

    // expected outcome straight from the branch rules
    function automatic exp_t expect_row(input row_t r, input int idx);
        exp_t        e;
        logic [31:0] tgt;
        logic        tk;
        case (r.op)
            OP_BEQ:  tk = (r.v1 == r.v2);
            OP_BNE:  tk = (r.v1 != r.v2);
            OP_BLT:  tk = ($signed(r.v1) < $signed(r.v2));
            OP_BGE:  tk = ($signed(r.v1) >= $signed(r.v2));
            OP_BLTU: tk = (r.v1 < r.v2);
            OP_BGEU: tk = (r.v1 >= r.v2);
            default: tk = 1'b1;  // jal and jalr
        endcase
        tgt = (r.op == OP_JALR) ? ((r.v1 + r.imm) & ~32'd1) : (r.pc + r.imm);
        e.idx        = idx[7:0];
        e.op         = r.op;
        e.taken      = tk;
        e.next_pc    = tk ? tgt : r.pc + 32'd4;
        e.link       = r.pc + 32'd4;
        e.rd         = r.rd;
        e.mispredict = (tk != r.pt) || (tk && tgt != r.ptgt);
        e.misaligned = tk && tgt[1];
        return e;
    endfunction

    task automatic take_result();
        exp_t e;
        if (exp_q.size() == 0) begin
            $display("unexpected result for rd %0d with next pc %h", res_rd, res_next_pc);
            errors++;
        end else begin
            e = exp_q.pop_front();
            row_ok = 1'b1;
            compare("res_taken", res_taken, e.taken);
            compare("res_next_pc", res_next_pc, e.next_pc);
            compare("res_link", res_link, e.link);
            compare("res_rd", res_rd, e.rd);
            compare("res_mispredict", res_mispredict, e.mispredict);
            compare("res_misaligned", res_misaligned, e.misaligned);
            compare("flush", flush_seen, e.mispredict);
            tests++;
            $display("row %0d %s %s", e.idx, e.op.name(), row_ok ? "ok" : "mismatch");
        end
    endtask

    // step to the next falling edge, result sampled there before the accepting edge
    task automatic next_cycle();
        @(negedge clk);
        res_ready = ($urandom % 3) != 0;
        if (i_branch_exec_top.flush) flush_seen = 1'b1;
        if (res_valid && res_ready) take_result();
    endtask

    task automatic broadcast(input logic a_en, input logic [5:0] a_tag, input logic [31:0] a_val,
                             input logic l_en, input logic [5:0] l_tag, input logic [31:0] l_val);
        alu_wb_valid = a_en;
        alu_wb_tag   = a_tag;
        alu_wb_data  = a_val;
        ld_wb_valid  = l_en;
        ld_wb_tag    = l_tag;
        ld_wb_data   = l_val;
        next_cycle();
        alu_wb_valid = 1'b0;
        ld_wb_valid  = 1'b0;
    endtask

    task automatic dispatch(input row_t r, input logic rdy);
        logic accepted;
        disp_valid       = 1'b1;
        disp_op          = r.op;
        disp_pc          = r.pc;
        disp_imm         = r.imm;
        disp_rs1         = r.t1;
        disp_rs2         = r.t2;
        disp_rs1_rdy     = rdy;
        disp_rs2_rdy     = rdy;
        disp_rd          = r.rd;
        disp_pred_taken  = r.pt;
        disp_pred_target = r.ptgt;
        accepted = 1'b0;
        while (!accepted) begin
            accepted = disp_ready;  // transfer on the coming edge
            next_cycle();
        end
        disp_valid = 1'b0;
    endtask

    initial begin
        row_t r;
        row_t s;
        rng_init = $urandom(87);
        add_row(OP_BEQ,  32'h100, 32'h20, 32'd5, 32'd5, 6'd1, 6'd2, 6'd3, 1, 32'h120, 0, 0);
        add_row(OP_BNE,  32'h200, 32'h40, 32'd7, 32'd7, 6'd4, 6'd5, 6'd6, 0, 32'h0, 0, 0);
        add_row(OP_BLT,  32'h300, 32'h10, 32'hffff_fff0, 32'd1, 6'd7, 6'd8, 6'd9, 0, 32'h0, 0, 1);
        add_row(OP_BGE,  32'h400, 32'h10, 32'hffff_fff0, 32'd1, 6'd10, 6'd11, 6'd12, 0, 32'h0, 0, 0);
        add_row(OP_BLTU, 32'h500, 32'h18, 32'hffff_fff0, 32'd1, 6'd13, 6'd14, 6'd15, 1, 32'h518, 0, 0);
        add_row(OP_BGEU, 32'h600, 32'h18, 32'hffff_fff0, 32'd1, 6'd16, 6'd17, 6'd18, 1, 32'h618, 0, 0);
        add_row(OP_BLT,  32'h700, 32'h8, 32'd3, 32'd9, 6'd19, 6'd20, 6'd21, 1, 32'h708, 1, 0);
        add_row(OP_JAL,  32'h800, 32'h100, 32'd0, 32'd0, 6'd22, 6'd23, 6'd24, 1, 32'h900, 0, 0);
        add_row(OP_JALR, 32'h900, 32'h10, 32'h1003, 32'd0, 6'd25, 6'd26, 6'd27, 1, 32'h1012, 0, 0);
        add_row(OP_JALR, 32'ha00, 32'h4, 32'h2000, 32'd0, 6'd28, 6'd29, 6'd30, 1, 32'h2008, 0, 1);
        add_row(OP_JAL,  32'h1000, 32'hffff_ff00, 32'd0, 32'd0, 6'd31, 6'd32, 6'd33, 0, 0, 0, 0);
        add_row(OP_BGEU, 32'hb00, 32'hffff_fff0, 32'd9, 32'd9, 6'd34, 6'd35, 6'd36, 0, 0, 1, 0);
        add_row(OP_BNE,  32'h40, 32'h6, 32'd1, 32'd2, 6'd37, 6'd38, 6'd39, 1, 32'h46, 0, 0);
        limit = rows.size() * 20 + 100;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        row_ok = 1'b1;
        compare("disp_ready", disp_ready, 1);
        compare("res_valid", res_valid, 0);
        compare("flush", i_branch_exec_top.flush, 0);
        tests++;
        $display("reset state %s", row_ok ? "ok" : "mismatch");

        foreach (rows[i]) begin
            r = rows[i];
            flush_seen = 1'b0;
            if (!r.late) broadcast(1, r.t1, r.v1, 1, r.t2, r.v2);
            dispatch(r, !r.late);
            if (r.shadow) begin
                s = r;
                s.pc = r.pc + 32'd4;
                s.rd = r.rd + 6'd1;
                dispatch(s, 1'b1);  // wrong path branch that the flush drops
            end
            if (r.late) begin
                repeat (3) next_cycle();
                broadcast(1, r.t1, r.v1, 0, 6'd0, 32'd0);
                repeat (3) next_cycle();  // one source still missing
                broadcast(0, 6'd0, 32'd0, 1, r.t2, r.v2);
            end
            exp_q.push_back(expect_row(r, i));
            while (exp_q.size() != 0) next_cycle();
            if (r.shadow) repeat (8) next_cycle();
        end

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- branch_exec_top.f
br_pkg.sv
phys_reg_file.sv
branch_rs.sv
branch_compare.sv
branch_target.sv
branch_resolve.sv
branch_exec_top.sv
tb_branch_exec.sv

//--- Bender.yml
package:
  name: branch_exec

sources:
  - br_pkg.sv
  - phys_reg_file.sv
  - branch_rs.sv
  - branch_compare.sv
  - branch_target.sv
  - branch_resolve.sv
  - branch_exec_top.sv
  - target: test
    files:
      - tb_branch_exec.sv
